// ==== branch_cfg.svh ====
`ifndef BRANCH_CFG_SVH
`define BRANCH_CFG_SVH

// slots in the prediction queue, at least three brs can be in flight
`define BR_QUEUE_DEPTH 4

// predictor index width, 16 counters
`define BHT_INDEX_BITS 4

`endif

// ==== branch_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_controller (
    input  lc3b_pipe_pkg::lc3b_fetch_snap               fetch,
    input  lc3b_pipe_pkg::lc3b_barrier_snap             if_id,
    input  lc3b_pipe_pkg::lc3b_barrier_snap             id_ex,
    input  lc3b_pipe_pkg::lc3b_ex_mem_snap              ex_mem,
    input  lc3b_pipe_pkg::lc3b_mem_wb_snap              mem_wb,
    input  logic                                        br_en,
    input  logic                                        prediction,
    input  lc3b_pipe_pkg::lc3b_pred_entry               head,
    output lc3b_isa_pkg::lc3b_word                      pc_out,
    output lc3b_isa_pkg::lc3b_word                      pc_plus2_out,
    output lc3b_pipe_pkg::lc3b_pipeline_control_request control_request,
    output logic                                        push,
    output lc3b_pipe_pkg::lc3b_pred_entry               push_entry,
    output logic                                        pop,
    output logic                                        flush,
    output logic                                        train,
    output lc3b_isa_pkg::lc3b_word                      train_pc,
    output logic                                        train_taken,
    output logic                                        resolved_correct,
    output logic                                        resolved_incorrect
);

    lc3b_isa_pkg::lc3b_opcode     fetch_opcode;
    lc3b_isa_pkg::lc3b_word       offset9;
    lc3b_isa_pkg::lc3b_word       branch_address;
    lc3b_isa_pkg::lc3b_pc_mux_sel pc_mux_sel;
    logic                         fetch_is_br;
    logic                         resolve_br;
    logic                         mispredict;
    logic                         jump_in_flight;

    // jmp, jsr and trap all redirect fetch
    function automatic logic is_jump(input lc3b_isa_pkg::lc3b_opcode op);
        return op == lc3b_isa_pkg::op_jmp ||
               op == lc3b_isa_pkg::op_jsr ||
               op == lc3b_isa_pkg::op_trap;
    endfunction

    assign fetch_opcode   = lc3b_isa_pkg::lc3b_opcode'(fetch.ir[15:12]);
    assign pc_plus2_out   = fetch.pc + 16'd2;
    assign offset9        = {{6{fetch.ir[8]}}, fetch.ir[8:0], 1'b0};
    assign branch_address = pc_plus2_out + offset9;

    assign fetch_is_br = fetch.valid && fetch_opcode == lc3b_isa_pkg::op_br;
    assign resolve_br  = ex_mem.valid && ex_mem.opcode == lc3b_isa_pkg::op_br;
    assign mispredict  = resolve_br && (head.prediction != br_en);

    // the queue head is the br now in ex/mem
    assign pop                = resolve_br;
    assign flush              = mispredict;
    assign train              = resolve_br;
    assign train_pc           = head.pc;
    assign train_taken        = br_en;
    assign resolved_correct   = resolve_br && !mispredict;
    assign resolved_incorrect = mispredict;

    // recovery address is the path not taken
    always_comb begin
        push_entry.prediction = prediction;
        push_entry.pc         = fetch.pc;
        if (prediction) begin
            push_entry.mispredict_address = pc_plus2_out;
        end else begin
            push_entry.mispredict_address = branch_address;
        end
    end

    always_comb begin
        control_request = '0;
        pc_mux_sel      = lc3b_isa_pkg::pc_plus2;
        jump_in_flight  = 1'b0;
        push            = 1'b0;

        if (if_id.valid && is_jump(if_id.opcode)) begin
            jump_in_flight        = 1'b1;
            control_request.if_id = 1'b1;
        end

        if (id_ex.valid && is_jump(id_ex.opcode)) begin
            jump_in_flight        = 1'b1;
            control_request.if_id = 1'b1;
            control_request.id_ex = 1'b1;
        end

        if (ex_mem.valid && is_jump(ex_mem.opcode)) begin
            jump_in_flight         = 1'b1;
            control_request.if_id  = 1'b1;
            control_request.id_ex  = 1'b1;
            control_request.ex_mem = 1'b1;
            // trap target only arrives from memory
            if (ex_mem.opcode != lc3b_isa_pkg::op_trap) begin
                pc_mux_sel = ex_mem.control.pc_mux_sel;
            end
        end

        if (mem_wb.valid && mem_wb.opcode == lc3b_isa_pkg::op_trap) begin
            jump_in_flight         = 1'b1;
            control_request.if_id  = 1'b1;
            control_request.id_ex  = 1'b1;
            control_request.ex_mem = 1'b1;
            control_request.mem_wb = 1'b1;
            pc_mux_sel             = mem_wb.control.pc_mux_sel;
        end

        // fetched br is dead if a jump is flushing behind it
        if (!jump_in_flight && fetch_is_br) begin
            push = 1'b1;
            if (prediction) begin
                pc_mux_sel = lc3b_isa_pkg::branch_address;
            end else begin
                pc_mux_sel = lc3b_isa_pkg::pc_plus2;
            end
        end

        if (resolve_br) begin
            if (mispredict) begin
                pc_mux_sel             = lc3b_isa_pkg::mispredict_address;
                control_request.if_id  = 1'b1;
                control_request.id_ex  = 1'b1;
                control_request.ex_mem = 1'b1;
            end else begin
                pc_mux_sel = lc3b_isa_pkg::pc_plus2;
            end
        end

        control_request.active = control_request.if_id  |
                                 control_request.id_ex  |
                                 control_request.ex_mem |
                                 control_request.mem_wb;
    end

    // next fetch pc
    always_comb begin
        case (pc_mux_sel)
            lc3b_isa_pkg::pc_plus2:           pc_out = pc_plus2_out;
            lc3b_isa_pkg::alu:                pc_out = ex_mem.alu;
            lc3b_isa_pkg::pcn:                pc_out = ex_mem.pcn;
            lc3b_isa_pkg::mdr:                pc_out = mem_wb.mdr;
            lc3b_isa_pkg::branch_address:     pc_out = branch_address;
            lc3b_isa_pkg::mispredict_address: pc_out = head.mispredict_address;
            default:                          pc_out = pc_plus2_out;
        endcase
    end

endmodule : branch_controller

`default_nettype wire

// ==== branch_predictor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_predictor (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stall,
    input  lc3b_isa_pkg::lc3b_word fetch_pc,
    output logic                   prediction,
    input  logic                   train,
    input  lc3b_isa_pkg::lc3b_word train_pc,
    input  logic                   train_taken
);

    localparam int INDEX_BITS = `BHT_INDEX_BITS;
    localparam int ENTRIES    = 1 << INDEX_BITS;

    logic [1:0]            counters [ENTRIES];
    logic [INDEX_BITS-1:0] fetch_index;
    logic [INDEX_BITS-1:0] train_index;
    logic [1:0]            train_count;

    // instructions are halfword aligned, bit 0 is always zero
    assign fetch_index = fetch_pc[INDEX_BITS:1];
    assign train_index = train_pc[INDEX_BITS:1];

    // top bit set means taken
    assign prediction  = counters[fetch_index][1];
    assign train_count = counters[train_index];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // weakly not-taken
            for (int i = 0; i < ENTRIES; i++) begin
                counters[i] <= 2'b01;
            end
        end else if (!stall && train) begin
            if (train_taken && train_count != 2'b11) begin
                counters[train_index] <= train_count + 2'd1;
            end else if (!train_taken && train_count != 2'b00) begin
                counters[train_index] <= train_count - 2'd1;
            end
        end
    end

endmodule : branch_predictor

`default_nettype wire

// ==== branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        stall,
    input  lc3b_pipe_pkg::lc3b_fetch_snap               fetch,
    input  lc3b_pipe_pkg::lc3b_barrier_snap             if_id,
    input  lc3b_pipe_pkg::lc3b_barrier_snap             id_ex,
    input  lc3b_pipe_pkg::lc3b_ex_mem_snap              ex_mem,
    input  lc3b_pipe_pkg::lc3b_mem_wb_snap              mem_wb,
    input  logic                                        br_en,
    output lc3b_isa_pkg::lc3b_word                      pc_out,
    output lc3b_isa_pkg::lc3b_word                      pc_plus2_out,
    output lc3b_pipe_pkg::lc3b_pipeline_control_request control_request,
    output logic                                        resolved_correct,
    output logic                                        resolved_incorrect
);

    logic                          prediction;
    logic                          push;
    lc3b_pipe_pkg::lc3b_pred_entry push_entry;
    logic                          pop;
    logic                          flush;
    lc3b_pipe_pkg::lc3b_pred_entry head;
    logic                          train;
    lc3b_isa_pkg::lc3b_word        train_pc;
    logic                          train_taken;

    branch_predictor predictor (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .fetch_pc    (fetch.pc),
        .prediction  (prediction),
        .train       (train),
        .train_pc    (train_pc),
        .train_taken (train_taken)
    );

    branch_waterfall_queue waterfall_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .push       (push),
        .push_entry (push_entry),
        .pop        (pop),
        .flush      (flush),
        .head       (head)
    );

    branch_controller controller (
        .fetch              (fetch),
        .if_id              (if_id),
        .id_ex              (id_ex),
        .ex_mem             (ex_mem),
        .mem_wb             (mem_wb),
        .br_en              (br_en),
        .prediction         (prediction),
        .head               (head),
        .pc_out             (pc_out),
        .pc_plus2_out       (pc_plus2_out),
        .control_request    (control_request),
        .push               (push),
        .push_entry         (push_entry),
        .pop                (pop),
        .flush              (flush),
        .train              (train),
        .train_pc           (train_pc),
        .train_taken        (train_taken),
        .resolved_correct   (resolved_correct),
        .resolved_incorrect (resolved_incorrect)
    );

endmodule : branch_unit

`default_nettype wire

// ==== branch_unit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_unit_assert (
    input logic                                        clk,
    input logic                                        rst_n,
    input logic                                        stall,
    input logic                                        push,
    input logic                                        pop,
    input logic                                        flush,
    input lc3b_pipe_pkg::lc3b_pipeline_control_request control_request
);

    localparam int DEPTH = `BR_QUEUE_DEPTH;

    int occupancy;
    int failures = 0;

    // queue fill followed from the same strobes the queue sees
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occupancy <= 0;
        end else if (!stall) begin
            if (flush) begin
                occupancy <= 0;
            end else begin
                occupancy <= occupancy + int'(push) - int'(pop);
            end
        end
    end

    no_push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (!stall && push && !flush) |-> (occupancy < DEPTH))
        else begin
            $error("br pushed into a full prediction queue");
            failures++;
        end

    no_pop_when_empty: assert property (@(posedge clk) disable iff (!rst_n)
        (!stall && pop) |-> (occupancy > 0))
        else begin
            $error("br resolved with an empty prediction queue");
            failures++;
        end

    active_matches_bits: assert property (@(posedge clk) disable iff (!rst_n)
        control_request.active == (control_request.if_id || control_request.id_ex ||
                                   control_request.ex_mem || control_request.mem_wb))
        else begin
            $error("control_request.active disagrees with the barrier reset bits");
            failures++;
        end

endmodule : branch_unit_assert

bind branch_unit branch_unit_assert queue_checks (
    .clk             (clk),
    .rst_n           (rst_n),
    .stall           (stall),
    .push            (push),
    .pop             (pop),
    .flush           (flush),
    .control_request (control_request)
);

`default_nettype wire

// ==== branch_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_unit_tb;

    typedef struct packed {
        lc3b_isa_pkg::lc3b_word                      pc;
        lc3b_pipe_pkg::lc3b_pipeline_control_request req;
        logic                                        push;
        lc3b_pipe_pkg::lc3b_pred_entry               entry;
        logic                                        good;
        logic                                        bad;
    } expect_t;

    logic                                        clk = 1'b0;
    logic                                        rst_n;
    logic                                        stall;
    logic                                        br_en;
    lc3b_pipe_pkg::lc3b_fetch_snap               fetch;
    lc3b_pipe_pkg::lc3b_barrier_snap             if_id;
    lc3b_pipe_pkg::lc3b_barrier_snap             id_ex;
    lc3b_pipe_pkg::lc3b_ex_mem_snap              ex_mem;
    lc3b_pipe_pkg::lc3b_mem_wb_snap              mem_wb;
    lc3b_isa_pkg::lc3b_word                      pc_out;
    lc3b_isa_pkg::lc3b_word                      pc_plus2_out;
    lc3b_pipe_pkg::lc3b_pipeline_control_request control_request;
    logic                                        resolved_correct;
    logic                                        resolved_incorrect;

    // model state, advanced at each unstalled edge
    lc3b_pipe_pkg::lc3b_pred_entry model_q [$];
    logic [1:0]                    model_cnt [1 << `BHT_INDEX_BITS];
    int                            errors = 0;
    int                            checks = 0;

    always #2 clk = ~clk;

    branch_unit dut (.*);

    function automatic logic jump_op(input lc3b_isa_pkg::lc3b_opcode op);
        return op inside {lc3b_isa_pkg::op_jmp, lc3b_isa_pkg::op_jsr, lc3b_isa_pkg::op_trap};
    endfunction

    function automatic expect_t ref_next();
        expect_t                       e;
        lc3b_pipe_pkg::lc3b_pred_entry oldest;
        lc3b_isa_pkg::lc3b_word        pc2;
        lc3b_isa_pkg::lc3b_word        target;
        logic                          guess;
        logic                          jumping;
        logic                          resolving;
        e = '0;
        oldest = '0;
        if (model_q.size() > 0) begin
            oldest = model_q[0];
        end
        pc2 = fetch.pc + 16'd2;
        target = pc2 + {{6{fetch.ir[8]}}, fetch.ir[8:0], 1'b0};
        guess = model_cnt[fetch.pc[`BHT_INDEX_BITS:1]][1];
        jumping = 1'b0;
        e.pc = pc2;
        if (if_id.valid && jump_op(if_id.opcode)) begin
            jumping = 1'b1;
            e.req |= 5'b01000;
        end
        if (id_ex.valid && jump_op(id_ex.opcode)) begin
            jumping = 1'b1;
            e.req |= 5'b01100;
        end
        if (ex_mem.valid && jump_op(ex_mem.opcode)) begin
            jumping = 1'b1;
            e.req |= 5'b01110;
            if (ex_mem.opcode != lc3b_isa_pkg::op_trap) begin
                e.pc = (ex_mem.control.pc_mux_sel == lc3b_isa_pkg::alu) ? ex_mem.alu : ex_mem.pcn;
            end
        end
        if (mem_wb.valid && mem_wb.opcode == lc3b_isa_pkg::op_trap) begin
            jumping = 1'b1;
            e.req |= 5'b01111;
            e.pc = mem_wb.mdr;
        end
        if (!jumping && fetch.valid && fetch.ir[15:12] == lc3b_isa_pkg::op_br) begin
            e.push = 1'b1;
            e.entry.prediction = guess;
            e.entry.pc = fetch.pc;
            e.entry.mispredict_address = guess ? pc2 : target;
            e.pc = guess ? target : pc2;
        end
        resolving = ex_mem.valid && ex_mem.opcode == lc3b_isa_pkg::op_br;
        if (resolving && oldest.prediction == br_en) begin
            e.good = 1'b1;
            e.pc = pc2;
        end else if (resolving) begin
            e.bad = 1'b1;
            e.pc = oldest.mispredict_address;
            e.req |= 5'b01110;
        end
        e.req.active = |e.req[3:0];
        return e;
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %0.1f ns %s expected %0h got %0h", $realtime, name, expected, actual);
        end
    endtask

    task automatic advance_model();
        expect_t e;
        int      idx;
        e = ref_next();
        if (!rst_n) begin
            model_q.delete();
            foreach (model_cnt[i]) model_cnt[i] = 2'b01;
        end else if (!stall) begin
            if (e.good || e.bad) begin
                if (model_q.size() == 0) begin
                    errors++;
                    $display("ERROR %0.1f ns br resolved with no prediction in flight", $realtime);
                end else begin
                    idx = int'(model_q[0].pc[`BHT_INDEX_BITS:1]);
                    if (br_en && model_cnt[idx] != 2'b11) begin
                        model_cnt[idx] = model_cnt[idx] + 2'd1;
                    end else if (!br_en && model_cnt[idx] != 2'b00) begin
                        model_cnt[idx] = model_cnt[idx] - 2'd1;
                    end
                    model_q.delete(0);
                end
                if (e.bad) model_q.delete();
            end
            if (e.push && !e.bad) model_q.push_back(e.entry);
        end
    endtask

    // model steps on the edge and outputs are compared half a ns before the next one
    initial begin
        expect_t e;
        forever begin
            @(posedge clk);
            advance_model();
            #3.5;
            if (rst_n) begin
                e = ref_next();
                check("pc_out", e.pc, pc_out);
                check("pc_plus2_out", 16'(fetch.pc + 16'd2), pc_plus2_out);
                check("control_request", e.req, control_request);
                check("resolved_correct", e.good, resolved_correct);
                check("resolved_incorrect", e.bad, resolved_incorrect);
                check("queue count", model_q.size(), dut.waterfall_queue.count);
                foreach (model_cnt[i]) begin
                    check($sformatf("counter[%0d]", i), model_cnt[i], dut.predictor.counters[i]);
                end
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic clear_inputs();
        stall = 1'b0;
        br_en = 1'b0;
        fetch.valid = 1'b1;
        fetch.ir = 16'h1000;
        if_id = '0;
        id_ex = '0;
        ex_mem = '0;
        mem_wb = '0;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            next_cycle();
            clear_inputs();
        end
    endtask

    task automatic fetch_br(input lc3b_isa_pkg::lc3b_word pc, input logic [8:0] offset);
        next_cycle();
        clear_inputs();
        fetch.pc = pc;
        fetch.ir = {4'b0000, 3'b111, offset};
    endtask

    task automatic resolve(input logic taken);
        next_cycle();
        clear_inputs();
        ex_mem.valid = 1'b1;
        ex_mem.opcode = lc3b_isa_pkg::op_br;
        br_en = taken;
    endtask

    function automatic lc3b_isa_pkg::lc3b_opcode pick_op();
        lc3b_isa_pkg::lc3b_opcode op;
        case ($urandom % 4)
            0: op = lc3b_isa_pkg::op_jmp;
            1: op = lc3b_isa_pkg::op_jsr;
            2: op = lc3b_isa_pkg::op_trap;
            default: op = lc3b_isa_pkg::op_add;
        endcase
        return op;
    endfunction

    // stage 0 to 3 is if_id, id_ex, ex_mem, mem_wb
    task automatic place_jump(input lc3b_isa_pkg::lc3b_opcode op, input int stage);
        lc3b_isa_pkg::lc3b_control_word cw;
        cw = '0;
        case (stage)
            0: if_id = '{1'b1, op, cw};
            1: id_ex = '{1'b1, op, cw};
            2: begin
                cw.pc_mux_sel = (op == lc3b_isa_pkg::op_jsr) ? lc3b_isa_pkg::pcn
                                                             : lc3b_isa_pkg::alu;
                ex_mem = '{1'b1, op, cw, 16'($urandom), 16'($urandom)};
            end
            default: begin
                cw.pc_mux_sel = lc3b_isa_pkg::mdr;
                mem_wb = '{1'b1, op, cw, 16'($urandom)};
            end
        endcase
    endtask

    task automatic report_test(input int num, input string name, input int start);
        $display("test %0d %-10s done, %0d mismatches", num, name, errors - start);
    endtask

    initial begin
        lc3b_isa_pkg::lc3b_opcode ops [3];
        lc3b_isa_pkg::lc3b_word   want;
        int                       start;
        int                       guard;
        ops = '{lc3b_isa_pkg::op_jmp, lc3b_isa_pkg::op_jsr, lc3b_isa_pkg::op_trap};
        void'($urandom(32'hf20));
        rst_n = 1'b0;
        fetch = '0;
        clear_inputs();
        fetch.valid = 1'b0;
        repeat (16) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        start = errors;
        #3;
        check("control_request", 0, control_request);
        check("resolved_incorrect", 0, resolved_incorrect);
        repeat (8) begin
            next_cycle();
            clear_inputs();
            fetch.pc = 16'($urandom) & 16'hfffe;
            #3;
            check("pc_out", 16'(fetch.pc + 16'd2), pc_out);
            check("control_request", 0, control_request);
        end
        report_test(1, "straight", start);

        // weakly not-taken br to 0x3022 that resolves taken
        start = errors;
        fetch_br(16'h3000, 9'h010);
        idle(2);
        resolve(1'b1);
        #3;
        check("resolved_incorrect", 1, resolved_incorrect);
        check("pc_out", 16'h3022, pc_out);
        check("control_request", 5'b11110, control_request);
        idle(1);
        check("queue count", 0, dut.waterfall_queue.count);
        report_test(2, "mispredict", start);

        start = errors;
        repeat (2) begin
            fetch_br(16'h3008, 9'h1f0);
            idle(2);
            resolve(1'b1);
        end
        fetch_br(16'h3008, 9'h1f0);
        #3;
        check("pc_out", 16'h2fea, pc_out);
        idle(2);
        resolve(1'b0);
        #3;
        check("resolved_incorrect", 1, resolved_incorrect);
        check("pc_out", 16'h300a, pc_out);
        report_test(3, "training", start);

        start = errors;
        foreach (ops[j]) begin
            for (int s = 0; s < 4; s++) begin
                if (s < 3 || ops[j] == lc3b_isa_pkg::op_trap) begin
                    fetch_br(16'($urandom) & 16'hfffe, 9'($urandom));
                    place_jump(ops[j], s);
                    #3;
                    want = fetch.pc + 16'd2;
                    if (s == 2 && ops[j] == lc3b_isa_pkg::op_jmp) want = ex_mem.alu;
                    if (s == 2 && ops[j] == lc3b_isa_pkg::op_jsr) want = ex_mem.pcn;
                    if (s == 3) want = mem_wb.mdr;
                    check("pc_out", want, pc_out);
                    check("control_request", 5'(5'b11111 << (3 - s)), control_request);
                end
            end
            idle(1);
            check("queue count", 0, dut.waterfall_queue.count);
        end
        report_test(4, "jumps", start);

        start = errors;
        fetch_br(16'h3040, 9'h004);
        fetch_br(16'h3052, 9'h1fc);
        repeat (4) begin
            fetch_br(16'h3060, 9'h008);
            stall = 1'b1;
            ex_mem.valid = 1'b1;
            ex_mem.opcode = lc3b_isa_pkg::op_br;
            br_en = 1'b1;
            #3;
            check("queue count", 2, dut.waterfall_queue.count);
        end
        resolve(1'b0);
        br_en = model_q[0].prediction;
        #3;
        check("resolved_correct", 1, resolved_correct);
        resolve(1'b0);
        br_en = !model_q[0].prediction;
        #3;
        check("resolved_incorrect", 1, resolved_incorrect);
        report_test(5, "stall", start);

        start = errors;
        repeat (300) begin
            next_cycle();
            clear_inputs();
            stall = ($urandom % 6) == 0;
            fetch.pc = 16'($urandom) & 16'hfffe;
            fetch.ir = 16'($urandom);
            if ($urandom % 3 == 0) fetch.ir[15:12] = 4'b0000;
            // at most three brs in flight
            if (fetch.ir[15:12] == 4'b0000 && model_q.size() >= 3) fetch.ir[15:12] = 4'b0001;
            for (int s = 0; s < 4; s++) begin
                if ($urandom % 6 == 0) place_jump(pick_op(), s);
            end
            if (model_q.size() > 0 && $urandom % 3 == 0) begin
                ex_mem = '0;
                ex_mem.valid = 1'b1;
                ex_mem.opcode = lc3b_isa_pkg::op_br;
                br_en = 1'($urandom);
            end
        end
        guard = 0;
        while (model_q.size() > 0 && guard < 20) begin
            resolve(1'b0);
            if (model_q.size() > 0) br_en = model_q[0].prediction;
            else ex_mem = '0;
            guard++;
        end
        idle(1);
        if (model_q.size() > 0) begin
            errors++;
            $display("ERROR prediction queue did not drain within 20 cycles");
        end
        report_test(6, "random", start);

        if (dut.queue_checks.failures > 0) begin
            errors += dut.queue_checks.failures;
            $display("ERROR %0d assertion failures in the bound queue checks",
                     dut.queue_checks.failures);
        end
        $display("6 tests, %0d checks, %0d mismatches", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (2000) @(posedge clk);
        $display("ERROR run did not complete within 2000 cycles");
        $display("Finished with errors");
        $finish;
    end

endmodule : branch_unit_tb

`default_nettype wire

// ==== branch_waterfall_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_cfg.svh"

module branch_waterfall_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          stall,
    input  logic                          push,
    input  lc3b_pipe_pkg::lc3b_pred_entry push_entry,
    input  logic                          pop,
    input  logic                          flush,
    output lc3b_pipe_pkg::lc3b_pred_entry head
);

    localparam int DEPTH    = `BR_QUEUE_DEPTH;
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    lc3b_pipe_pkg::lc3b_pred_entry entries [DEPTH];

    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0] count;
    logic                full;
    logic                empty;
    logic                do_push;
    logic                do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_BITS-1:0] ptr_inc(input logic [PTR_BITS-1:0] ptr);
        logic [PTR_BITS-1:0] next;
        if (ptr == PTR_BITS'(DEPTH - 1)) begin
            next = '0;
        end else begin
            next = ptr + 1'b1;
        end
        return next;
    endfunction

    assign full  = (count == CNT_BITS'(DEPTH));
    assign empty = (count == '0);

    // a push in a flush cycle belongs to a squashed br
    assign do_push = push && !flush && !full;
    assign do_pop  = pop && !empty;

    // oldest entry is always the br sitting in ex/mem
    assign head = entries[rd_ptr];

    always_ff @(posedge clk) begin
        if (!stall && do_push) begin
            entries[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else if (!stall) begin
            if (flush) begin
                // pop and empty in one step
                rd_ptr <= '0;
                wr_ptr <= '0;
                count  <= '0;
            end else begin
                if (do_push) begin
                    wr_ptr <= ptr_inc(wr_ptr);
                end
                if (do_pop) begin
                    rd_ptr <= ptr_inc(rd_ptr);
                end
                count <= count + CNT_BITS'(do_push) - CNT_BITS'(do_pop);
            end
        end
    end

endmodule : branch_waterfall_queue

`default_nettype wire

// ==== lc3b_isa_pkg.sv ====
`default_nettype none

package lc3b_isa_pkg;

    typedef logic [15:0] lc3b_word;

    // instruction bits [15:12]
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass,
        alu_sll,
        alu_srl,
        alu_sra
    } lc3b_aluop;

    // next fetch pc sources
    typedef enum logic [2:0] {
        pc_plus2           = 3'd0,
        alu                = 3'd1,
        pcn                = 3'd2,
        mdr                = 3'd3,
        branch_address     = 3'd4,
        mispredict_address = 3'd5
    } lc3b_pc_mux_sel;

    typedef struct packed {
        lc3b_aluop      aluop;
        logic           load_regfile;
        logic           load_cc;
        logic           mem_read;
        logic           mem_write;
        lc3b_pc_mux_sel pc_mux_sel;
    } lc3b_control_word;

endpackage : lc3b_isa_pkg

`default_nettype wire

// ==== lc3b_pipe_pkg.sv ====
`default_nettype none

package lc3b_pipe_pkg;

    typedef struct packed {
        logic                   valid;
        lc3b_isa_pkg::lc3b_word ir;
        lc3b_isa_pkg::lc3b_word pc;
    } lc3b_fetch_snap;

    typedef struct packed {
        logic                           valid;
        lc3b_isa_pkg::lc3b_opcode       opcode;
        lc3b_isa_pkg::lc3b_control_word control;
    } lc3b_barrier_snap;

    // barrier fields plus the ex results feeding the pc mux
    typedef struct packed {
        logic                           valid;
        lc3b_isa_pkg::lc3b_opcode       opcode;
        lc3b_isa_pkg::lc3b_control_word control;
        lc3b_isa_pkg::lc3b_word         alu;
        lc3b_isa_pkg::lc3b_word         pcn;
    } lc3b_ex_mem_snap;

    typedef struct packed {
        logic                           valid;
        lc3b_isa_pkg::lc3b_opcode       opcode;
        lc3b_isa_pkg::lc3b_control_word control;
        lc3b_isa_pkg::lc3b_word         mdr;
    } lc3b_mem_wb_snap;

    // one in-flight br
    typedef struct packed {
        logic                   prediction;
        lc3b_isa_pkg::lc3b_word mispredict_address;
        lc3b_isa_pkg::lc3b_word pc;
    } lc3b_pred_entry;

    typedef struct packed {
        logic active;
        logic if_id;
        logic id_ex;
        logic ex_mem;
        logic mem_wb;
    } lc3b_pipeline_control_request;

endpackage : lc3b_pipe_pkg

`default_nettype wire

// ==== tb.f ====
+incdir+.
lc3b_isa_pkg.sv
lc3b_pipe_pkg.sv
branch_predictor.sv
branch_waterfall_queue.sv
branch_controller.sv
branch_unit.sv
branch_unit_assert.sv
branch_unit_tb.sv
